// ==== common/issue_pkg.sv ====
package issue_pkg;

    // ------------------------------
    // data widths
    // ------------------------------
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;    // operand or result.
    typedef logic [XLEN-1:0] pc_t;
    typedef logic [XLEN-1:0] imm_t;

    // ------------------------------
    // instruction fields
    // ------------------------------
    typedef logic [4:0] reg_t;          // r0 is hardwired zero.
    typedef logic [3:0] op_t;           // op code within a unit.

    localparam int NUM_REGS = 1 << $bits(reg_t);

    // target execution unit and the index of its output slot in dispatch.
    typedef enum logic [0:0] {
        EX_ALU = 1'b0,
        EX_LSU = 1'b1
    } ex_type_t;

endpackage

// ==== issue/dispatch.sv ====
module dispatch import issue_pkg::*; #(
    parameter int NUM_WARPS = 4,
    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             issue_fire,
    input  ex_type_t         head_ex_type,
    input  logic [WID_W-1:0] head_wid,
    input  pc_t              head_pc,
    input  op_t              head_op,
    input  imm_t             head_imm,
    input  reg_t             head_rd,
    input  logic             head_wb,
    input  word_t            rs1_data,
    input  word_t            rs2_data,
    output logic             disp_ready,

    output logic             alu_valid,
    input  logic             alu_ready,
    output logic [WID_W-1:0] alu_wid,
    output pc_t              alu_pc,
    output op_t              alu_op,
    output imm_t             alu_imm,
    output reg_t             alu_rd,
    output logic             alu_wb,
    output word_t            alu_rs1_data,
    output word_t            alu_rs2_data,

    output logic             lsu_valid,
    input  logic             lsu_ready,
    output logic [WID_W-1:0] lsu_wid,
    output pc_t              lsu_pc,
    output op_t              lsu_op,
    output imm_t             lsu_imm,
    output reg_t             lsu_rd,
    output logic             lsu_wb,
    output word_t            lsu_rs1_data,
    output word_t            lsu_rs2_data
);
    localparam int NUM_UNITS = 2;

    // one output slot per unit indexed by ex_type_t.
    logic [NUM_UNITS-1:0] valid_q;
    logic [NUM_UNITS-1:0] ready_in;
    logic [NUM_UNITS-1:0] wb_q;
    logic [WID_W-1:0]     wid_q [NUM_UNITS];
    pc_t                  pc_q  [NUM_UNITS];
    op_t                  op_q  [NUM_UNITS];
    imm_t                 imm_q [NUM_UNITS];
    reg_t                 rd_q  [NUM_UNITS];
    word_t                rs1_q [NUM_UNITS];
    word_t                rs2_q [NUM_UNITS];

    assign ready_in   = {lsu_ready, alu_ready};
    assign disp_ready = !valid_q[head_ex_type] || ready_in[head_ex_type];   // empty or draining.

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                if (issue_fire && int'(head_ex_type) == u) begin
                    valid_q[u] <= 1'b1;
                end else if (ready_in[u]) begin
                    valid_q[u] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (issue_fire && int'(head_ex_type) == u) begin
                wid_q[u] <= head_wid;
                pc_q[u]  <= head_pc;
                op_q[u]  <= head_op;
                imm_q[u] <= head_imm;
                rd_q[u]  <= head_rd;
                wb_q[u]  <= head_wb;
                rs1_q[u] <= rs1_data;
                rs2_q[u] <= rs2_data;
            end
        end
    end

    // ------------------------------
    // unit ports
    // ------------------------------
    assign alu_valid    = valid_q[EX_ALU];
    assign alu_wid      = wid_q[EX_ALU];
    assign alu_pc       = pc_q[EX_ALU];
    assign alu_op       = op_q[EX_ALU];
    assign alu_imm      = imm_q[EX_ALU];
    assign alu_rd       = rd_q[EX_ALU];
    assign alu_wb       = wb_q[EX_ALU];
    assign alu_rs1_data = rs1_q[EX_ALU];
    assign alu_rs2_data = rs2_q[EX_ALU];

    assign lsu_valid    = valid_q[EX_LSU];
    assign lsu_wid      = wid_q[EX_LSU];
    assign lsu_pc       = pc_q[EX_LSU];
    assign lsu_op       = op_q[EX_LSU];
    assign lsu_imm      = imm_q[EX_LSU];
    assign lsu_rd       = rd_q[EX_LSU];
    assign lsu_wb       = wb_q[EX_LSU];
    assign lsu_rs1_data = rs1_q[EX_LSU];
    assign lsu_rs2_data = rs2_q[EX_LSU];

endmodule

// ==== issue/gpr_file.sv ====
module gpr_file import issue_pkg::*; #(
    parameter int NUM_WARPS = 4,
    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic             clk,
    input  logic             reset,

    input  logic [WID_W-1:0] head_wid,
    input  reg_t             head_rs1,
    input  reg_t             head_rs2,

    input  logic             wb_valid,
    input  logic [WID_W-1:0] wb_wid,
    input  reg_t             wb_rd,
    input  word_t            wb_data,

    output word_t            rs1_data,
    output word_t            rs2_data
);
    word_t regs [NUM_WARPS][NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                for (int r = 0; r < NUM_REGS; r++) begin
                    regs[w][r] <= '0;
                end
            end
        end else if (wb_valid && wb_rd != '0) begin
            regs[wb_wid][wb_rd] <= wb_data;
        end
    end

    // async read ports.
    assign rs1_data = (head_rs1 == '0) ? '0 : regs[head_wid][head_rs1];
    assign rs2_data = (head_rs2 == '0) ? '0 : regs[head_wid][head_rs2];

endmodule

// ==== issue/ibuffer.sv ====
module ibuffer import issue_pkg::*; #(
    parameter int NUM_WARPS  = 4,
    parameter int IBUF_DEPTH = 4,
    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             decode_valid,
    output logic             decode_ready,
    input  logic [WID_W-1:0] decode_wid,
    input  pc_t              decode_pc,
    input  ex_type_t         decode_ex_type,
    input  op_t              decode_op,
    input  logic             decode_wb,
    input  reg_t             decode_rd,
    input  reg_t             decode_rs1,
    input  reg_t             decode_rs2,
    input  imm_t             decode_imm,

    input  logic             pop,
    output logic             head_valid,
    output logic [WID_W-1:0] head_wid,
    output pc_t              head_pc,
    output ex_type_t         head_ex_type,
    output op_t              head_op,
    output logic             head_wb,
    output reg_t             head_rd,
    output reg_t             head_rs1,
    output reg_t             head_rs2,
    output imm_t             head_imm
);
    localparam int PTR_W = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(IBUF_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    pc_t      pc_q  [NUM_WARPS][IBUF_DEPTH];
    ex_type_t ex_q  [NUM_WARPS][IBUF_DEPTH];
    op_t      op_q  [NUM_WARPS][IBUF_DEPTH];
    logic     wb_q  [NUM_WARPS][IBUF_DEPTH];
    reg_t     rd_q  [NUM_WARPS][IBUF_DEPTH];
    reg_t     rs1_q [NUM_WARPS][IBUF_DEPTH];
    reg_t     rs2_q [NUM_WARPS][IBUF_DEPTH];
    imm_t     imm_q [NUM_WARPS][IBUF_DEPTH];

    ptr_t             rd_ptr   [NUM_WARPS];
    ptr_t             wr_ptr   [NUM_WARPS];
    cnt_t             count    [NUM_WARPS];
    cnt_t             cnt_next [NUM_WARPS];
    logic [WID_W-1:0] rr_ptr;
    logic [WID_W-1:0] rr_next;
    logic             push;

    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(IBUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign decode_ready = (count[decode_wid] != cnt_t'(IBUF_DEPTH));
    assign push         = decode_valid && decode_ready;

    // ------------------------------
    // occupancy and warp select
    // ------------------------------
    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            cnt_next[w] = count[w];
            if (push && decode_wid == WID_W'(w)) begin
                cnt_next[w] = cnt_next[w] + 1'b1;
            end
            if (pop && head_wid == WID_W'(w)) begin
                cnt_next[w] = cnt_next[w] - 1'b1;
            end
        end
    end

    // next non-empty warp after rr_ptr with rr_ptr itself tried last.
    always_comb begin
        int idx;
        rr_next = rr_ptr;
        for (int i = NUM_WARPS; i >= 1; i--) begin
            idx = (int'(rr_ptr) + i) % NUM_WARPS;
            if (cnt_next[idx] != '0) begin
                rr_next = WID_W'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
            for (int w = 0; w < NUM_WARPS; w++) begin
                rd_ptr[w] <= '0;
                wr_ptr[w] <= '0;
                count[w]  <= '0;
            end
        end else begin
            rr_ptr <= rr_next;     // moves every cycle whether fired or not.
            for (int w = 0; w < NUM_WARPS; w++) begin
                count[w] <= cnt_next[w];
                if (push && decode_wid == WID_W'(w)) begin
                    wr_ptr[w] <= ptr_inc(wr_ptr[w]);
                end
                if (pop && head_wid == WID_W'(w)) begin
                    rd_ptr[w] <= ptr_inc(rd_ptr[w]);
                end
            end
        end
    end

    // ------------------------------
    // queue storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (push) begin
            pc_q[decode_wid][wr_ptr[decode_wid]]  <= decode_pc;
            ex_q[decode_wid][wr_ptr[decode_wid]]  <= decode_ex_type;
            op_q[decode_wid][wr_ptr[decode_wid]]  <= decode_op;
            wb_q[decode_wid][wr_ptr[decode_wid]]  <= decode_wb;
            rd_q[decode_wid][wr_ptr[decode_wid]]  <= decode_rd;
            rs1_q[decode_wid][wr_ptr[decode_wid]] <= decode_rs1;
            rs2_q[decode_wid][wr_ptr[decode_wid]] <= decode_rs2;
            imm_q[decode_wid][wr_ptr[decode_wid]] <= decode_imm;
        end
    end

    assign head_wid     = rr_ptr;
    assign head_valid   = (count[rr_ptr] != '0);
    assign head_pc      = pc_q[rr_ptr][rd_ptr[rr_ptr]];
    assign head_ex_type = ex_q[rr_ptr][rd_ptr[rr_ptr]];
    assign head_op      = op_q[rr_ptr][rd_ptr[rr_ptr]];
    assign head_wb      = wb_q[rr_ptr][rd_ptr[rr_ptr]];
    assign head_rd      = rd_q[rr_ptr][rd_ptr[rr_ptr]];
    assign head_rs1     = rs1_q[rr_ptr][rd_ptr[rr_ptr]];
    assign head_rs2     = rs2_q[rr_ptr][rd_ptr[rr_ptr]];
    assign head_imm     = imm_q[rr_ptr][rd_ptr[rr_ptr]];

endmodule

// ==== issue/issue_top.sv ====
module issue_top import issue_pkg::*; #(
    parameter int NUM_WARPS  = 4,
    parameter int IBUF_DEPTH = 4,
    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             decode_valid,
    output logic             decode_ready,
    input  logic [WID_W-1:0] decode_wid,
    input  pc_t              decode_pc,
    input  ex_type_t         decode_ex_type,
    input  op_t              decode_op,
    input  logic             decode_wb,
    input  reg_t             decode_rd,
    input  reg_t             decode_rs1,
    input  reg_t             decode_rs2,
    input  imm_t             decode_imm,

    input  logic             wb_valid,
    input  logic [WID_W-1:0] wb_wid,
    input  reg_t             wb_rd,
    input  word_t            wb_data,

    output logic             alu_valid,
    input  logic             alu_ready,
    output logic [WID_W-1:0] alu_wid,
    output pc_t              alu_pc,
    output op_t              alu_op,
    output imm_t             alu_imm,
    output reg_t             alu_rd,
    output logic             alu_wb,
    output word_t            alu_rs1_data,
    output word_t            alu_rs2_data,

    output logic             lsu_valid,
    input  logic             lsu_ready,
    output logic [WID_W-1:0] lsu_wid,
    output pc_t              lsu_pc,
    output op_t              lsu_op,
    output imm_t             lsu_imm,
    output reg_t             lsu_rd,
    output logic             lsu_wb,
    output word_t            lsu_rs1_data,
    output word_t            lsu_rs2_data
);
    logic             head_valid;
    logic [WID_W-1:0] head_wid;
    pc_t              head_pc;
    ex_type_t         head_ex_type;
    op_t              head_op;
    logic             head_wb;
    reg_t             head_rd;
    reg_t             head_rs1;
    reg_t             head_rs2;
    imm_t             head_imm;
    word_t            rs1_data;
    word_t            rs2_data;
    logic             sb_ready;
    logic             disp_ready;
    logic             issue_fire;

    // head leaves only when operands are free and its unit slot can take it.
    assign issue_fire = head_valid && sb_ready && disp_ready;

    ibuffer #(
        .NUM_WARPS  (NUM_WARPS),
        .IBUF_DEPTH (IBUF_DEPTH)
    ) u_ibuffer (
        .pop (issue_fire),
        .*
    );

    scoreboard #(
        .NUM_WARPS (NUM_WARPS)
    ) u_scoreboard (.*);

    gpr_file #(
        .NUM_WARPS (NUM_WARPS)
    ) u_gpr_file (.*);

    dispatch #(
        .NUM_WARPS (NUM_WARPS)
    ) u_dispatch (.*);

endmodule

// ==== issue/scoreboard.sv ====
module scoreboard import issue_pkg::*; #(
    parameter int NUM_WARPS = 4,
    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic             clk,
    input  logic             reset,

    input  logic [WID_W-1:0] head_wid,
    input  reg_t             head_rs1,
    input  reg_t             head_rs2,
    input  reg_t             head_rd,
    input  logic             head_wb,
    input  logic             issue_fire,

    input  logic             wb_valid,
    input  logic [WID_W-1:0] wb_wid,
    input  reg_t             wb_rd,

    output logic             sb_ready
);
    logic [NUM_REGS-1:0] pending [NUM_WARPS];
    logic                rs1_busy;
    logic                rs2_busy;
    logic                rd_busy;

    // ------------------------------
    // hazard check
    // ------------------------------
    assign rs1_busy = pending[head_wid][head_rs1];
    assign rs2_busy = pending[head_wid][head_rs2];
    assign rd_busy  = pending[head_wid][head_rd];     // waw guard.

    assign sb_ready = !(rs1_busy || rs2_busy || rd_busy);

    // ------------------------------
    // pending bits
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                pending[w] <= '0;
            end
        end else begin
            if (wb_valid) begin
                pending[wb_wid][wb_rd] <= 1'b0;
            end
            // a firing head never targets a pending rd, so no overlap with the clear.
            if (issue_fire && head_wb && head_rd != '0) begin
                pending[head_wid][head_rd] <= 1'b1;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert -j 0 --top-module issue_tb -f src.f -o issue_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/issue_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

// ==== sim/issue_properties.sv ====
module issue_properties import issue_pkg::*; #(
    parameter int FIELD_W = 140
) (
    input logic               clk,
    input logic               reset,
    input logic               alu_valid,
    input logic               alu_ready,
    input logic [FIELD_W-1:0] alu_fields,
    input logic               lsu_valid,
    input logic               lsu_ready,
    input logic [FIELD_W-1:0] lsu_fields,
    input logic               wb_valid,
    input reg_t               wb_rd,
    input logic               wb_pending
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // held ports keep valid and payload.
    alu_hold: assert property (@(posedge clk) disable iff (reset)
        alu_valid && !alu_ready |=> alu_valid && $stable(alu_fields))
        else begin fail_count++; $error("alu port changed while held"); end

    lsu_hold: assert property (@(posedge clk) disable iff (reset)
        lsu_valid && !lsu_ready |=> lsu_valid && $stable(lsu_fields))
        else begin fail_count++; $error("lsu port changed while held"); end

    wb_known: assert property (@(posedge clk) disable iff (reset)
        wb_valid && wb_rd != '0 |-> wb_pending)
        else begin fail_count++; $error("writeback to a register that is not pending"); end

endmodule

bind issue_top issue_properties props (
    .clk        (clk),
    .reset      (reset),
    .alu_valid  (alu_valid),
    .alu_ready  (alu_ready),
    .alu_fields ({alu_wid, alu_pc, alu_op, alu_imm, alu_rd, alu_wb, alu_rs1_data, alu_rs2_data}),
    .lsu_valid  (lsu_valid),
    .lsu_ready  (lsu_ready),
    .lsu_fields ({lsu_wid, lsu_pc, lsu_op, lsu_imm, lsu_rd, lsu_wb, lsu_rs1_data, lsu_rs2_data}),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_pending (u_scoreboard.pending[wb_wid][wb_rd])
);

// ==== sim/issue_tb.sv ====
module issue_tb import issue_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_WARPS    = 4;
    localparam int WID_W        = 2;
    localparam int NUM_INSTR    = 240;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = NUM_INSTR * 40 + RESET_CYCLES;

    logic             clk = 1'b0;
    logic             reset;
    logic             decode_valid, decode_ready, decode_wb;
    logic [WID_W-1:0] decode_wid;
    pc_t              decode_pc;
    ex_type_t         decode_ex_type;
    op_t              decode_op;
    reg_t             decode_rd, decode_rs1, decode_rs2;
    imm_t             decode_imm;
    logic             wb_valid;
    logic [WID_W-1:0] wb_wid;
    reg_t             wb_rd;
    word_t            wb_data;
    logic             alu_valid, alu_ready, alu_wb, lsu_valid, lsu_ready, lsu_wb;
    logic [WID_W-1:0] alu_wid, lsu_wid;
    pc_t              alu_pc, lsu_pc;
    op_t              alu_op, lsu_op;
    imm_t             alu_imm, lsu_imm;
    reg_t             alu_rd, lsu_rd;
    word_t            alu_rs1_data, alu_rs2_data, lsu_rs1_data, lsu_rs2_data;

    // ------------------------------
    // reference model state
    // ------------------------------
    logic [WID_W-1:0] wid_of [NUM_INSTR];
    pc_t              pc_of [NUM_INSTR];
    op_t              op_of [NUM_INSTR];
    imm_t             imm_of [NUM_INSTR];
    reg_t             rd_of [NUM_INSTR];
    logic             wb_of [NUM_INSTR];
    int               src1_of [NUM_INSTR];     // last older writer of rs1 or -1 if none.
    int               src2_of [NUM_INSTR];
    word_t            result_of [NUM_INSTR];
    logic             done_of [NUM_INSTR];
    int               last_writer [NUM_WARPS][NUM_REGS];
    int               exp_q [NUM_WARPS][2][$];
    int               resp_seq [$];
    int               resp_due [$];
    int               resp_cur;
    int               decoded = 0;
    int               retired = 0;
    int               cycle = 0;
    logic             taken;
    logic [31:0]      lfsr = 32'he9e4d727;

    issue_top #(.NUM_WARPS(NUM_WARPS), .IBUF_DEPTH(4)) DUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] take(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // the operand carries the result of its last older writer.
    function automatic word_t expected_operand(input int src);
        if (src < 0) begin
            return '0;
        end
        return result_of[src];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR %s expected %h actual %h", name, exp, act);
        $display("Checks failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic record_decode();
        int s;
        s = decoded;
        wid_of[s]  = decode_wid;
        pc_of[s]   = decode_pc;
        op_of[s]   = decode_op;
        imm_of[s]  = decode_imm;
        rd_of[s]   = decode_rd;
        wb_of[s]   = decode_wb;
        src1_of[s] = (decode_rs1 == '0) ? -1 : last_writer[decode_wid][decode_rs1];
        src2_of[s] = (decode_rs2 == '0) ? -1 : last_writer[decode_wid][decode_rs2];
        if (decode_wb && decode_rd != '0) begin
            last_writer[decode_wid][decode_rd] = s;
        end
        exp_q[decode_wid][int'(decode_ex_type)].push_back(s);
        decoded++;
    endtask

    task automatic check_transfer(input int unit, input logic [WID_W-1:0] wid, input pc_t pc,
                                  input op_t op, input imm_t imm, input reg_t rd, input logic wb,
                                  input word_t a, input word_t b);
        int    s;
        string name;
        name = (unit == 0) ? "alu" : "lsu";
        if (exp_q[wid][unit].size() == 0) begin
            fail_run($sformatf("%s transfer for warp %0d with nothing outstanding", name, wid));
        end else begin
            s = exp_q[wid][unit].pop_front();    // oldest of this warp and unit.
            assert (pc == pc_of[s]) else value_error({name, " pc"}, pc_of[s], pc);
            assert (op == op_of[s]) else value_error({name, " op"}, 32'(op_of[s]), 32'(op));
            assert (imm == imm_of[s]) else value_error({name, " imm"}, imm_of[s], imm);
            assert (rd == rd_of[s]) else value_error({name, " rd"}, 32'(rd_of[s]), 32'(rd));
            assert (wb == wb_of[s]) else value_error({name, " wb"}, 32'(wb_of[s]), 32'(wb));
            assert (src1_of[s] < 0 || done_of[src1_of[s]])
                else fail_run({name, " rs1 read before its writer returned"});
            assert (src2_of[s] < 0 || done_of[src2_of[s]])
                else fail_run({name, " rs2 read before its writer returned"});
            assert (a == expected_operand(src1_of[s]))
                else value_error({name, " rs1_data"}, expected_operand(src1_of[s]), a);
            assert (b == expected_operand(src2_of[s]))
                else value_error({name, " rs2_data"}, expected_operand(src2_of[s]), b);
            if (wb && rd != '0) begin
                resp_seq.push_back(s);
                resp_due.push_back(cycle + int'(take(3)));
            end
            retired++;
        end
    endtask

    // ------------------------------
    // compare process
    // ------------------------------
    always @(posedge clk) begin
        if (!reset) begin
            if (decode_valid && decode_ready) record_decode();
            if (wb_valid) begin
                result_of[resp_cur] = wb_data;
                done_of[resp_cur]   = 1'b1;
            end
            if (alu_valid && alu_ready) begin
                check_transfer(0, alu_wid, alu_pc, alu_op, alu_imm, alu_rd, alu_wb,
                               alu_rs1_data, alu_rs2_data);
            end
            if (lsu_valid && lsu_ready) begin
                check_transfer(1, lsu_wid, lsu_pc, lsu_op, lsu_imm, lsu_rd, lsu_wb,
                               lsu_rs1_data, lsu_rs2_data);
            end
        end
        cycle++;
        if (cycle >= MAX_CYCLES) fail_run("timeout, instructions still outstanding");
    end

    // execution units with random ready and delayed writebacks.
    always @(negedge clk) begin
        int pick;
        pick = -1;
        wb_valid = 1'b0;
        if (!reset) begin
            alu_ready = (take(2) != 0);
            lsu_ready = (take(2) != 0);
            foreach (resp_seq[i]) begin
                if (pick < 0 && resp_due[i] <= cycle) pick = i;
            end
            if (pick >= 0) begin
                resp_cur = resp_seq[pick];
                wb_wid   = wid_of[resp_cur];
                wb_rd    = rd_of[resp_cur];
                wb_data  = take(32);
                wb_valid = 1'b1;
                resp_seq.delete(pick);
                resp_due.delete(pick);
            end
        end
    end

    // ------------------------------
    // decoder stimulus
    // ------------------------------
    initial begin
        reset = 1'b1;
        decode_valid = 1'b0;
        decode_wid = '0;
        decode_pc = '0;
        decode_ex_type = EX_ALU;
        decode_op = '0;
        decode_wb = 1'b0;
        decode_rd = '0;
        decode_rs1 = '0;
        decode_rs2 = '0;
        decode_imm = '0;
        wb_valid = 1'b0;
        wb_wid = '0;
        wb_rd = '0;
        wb_data = '0;
        alu_ready = 1'b0;
        lsu_ready = 1'b0;
        foreach (done_of[i]) done_of[i] = 1'b0;
        foreach (last_writer[w, r]) last_writer[w][r] = -1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            decode_wid = WID_W'(w);
            #1;
            assert (decode_ready) else fail_run("decode_ready low after reset");
        end
        assert (!alu_valid && !lsu_valid) else fail_run("exec valid high after reset");
        @(negedge clk);
        for (int s = 0; s < NUM_INSTR; s++) begin
            while (take(2) == 0) @(negedge clk);     // idle gap.
            decode_wid     = WID_W'(take(2));
            decode_pc      = pc_t'(32'h1000 + s * 4);
            decode_ex_type = ex_type_t'(take(1));
            decode_op      = op_t'(take(4));
            decode_wb      = (take(2) != 0);
            decode_rd      = reg_t'(take(2));
            decode_rs1     = reg_t'(take(2));
            decode_rs2     = reg_t'(take(2));
            decode_imm     = take(32);
            decode_valid   = 1'b1;
            do begin
                @(posedge clk);
                taken = decode_ready;
                @(negedge clk);
            end while (!taken);
            decode_valid = 1'b0;
        end
        while (retired < NUM_INSTR || resp_seq.size() != 0 || wb_valid) @(posedge clk);
        @(negedge clk);
        assert (!alu_valid && !lsu_valid)
            else fail_run("exec port valid after every instruction has left");
        if (DUT.props.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            fail_run("handshake property failed");
        end
    end

endmodule

// ==== src.f ====
common/issue_pkg.sv
issue/ibuffer.sv
issue/scoreboard.sv
issue/gpr_file.sv
issue/dispatch.sv
issue/issue_top.sv
sim/issue_properties.sv
sim/issue_tb.sv
